//--- soc_pkg.sv
package soc_pkg;

   // Bus geometry.
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int SEL_W  = 4;   // One select per byte lane.

   localparam int MEM_WORDS = 4096; // RAM depth in words.

   // Cycles of internal reset after the external reset is released.
   localparam int RST_STRETCH = 5;

   // Region is picked by address bits 31:28.
   localparam logic [3:0] REGION_MEM   = 4'h0;
   localparam logic [3:0] REGION_PRINT = 4'h1;
   localparam logic [3:0] REGION_TIMER = 4'h8;
   localparam logic [3:0] REGION_HALT  = 4'h9;

   // Compare value that keeps the timer interrupt quiet.
   localparam logic [DATA_W-1:0] TIMECMP_RESET = '1;

   typedef enum logic [2:0] {
      RGN_MEM,
      RGN_PRINT,
      RGN_TIMER,
      RGN_HALT,
      RGN_NONE     // Unmapped and acked by the intercon.
   } region_e;

   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_IBUS,
      ARB_DBUS
   } arb_state_e;

endpackage

//--- wb_intercon.sv
`timescale 1ns/1ps
`default_nettype none
module wb_intercon (
   input  logic                        wb_clk,
   input  logic                        i_rst_n,
   input  logic [soc_pkg::ADDR_W-1:0] i_ibus_adr,
   input  logic                        i_ibus_cyc,
   input  logic                        i_ibus_stb,
   output logic [soc_pkg::DATA_W-1:0] o_ibus_rdt,
   output logic                        o_ibus_ack,
   input  logic [soc_pkg::ADDR_W-1:0] i_dbus_adr,
   input  logic [soc_pkg::DATA_W-1:0] i_dbus_dat,
   input  logic [soc_pkg::SEL_W-1:0]  i_dbus_sel,
   input  logic                        i_dbus_we,
   input  logic                        i_dbus_cyc,
   input  logic                        i_dbus_stb,
   output logic [soc_pkg::DATA_W-1:0] o_dbus_rdt,
   output logic                        o_dbus_ack,
   output logic [soc_pkg::ADDR_W-1:0] o_slv_adr,
   output logic [soc_pkg::DATA_W-1:0] o_slv_dat,
   output logic [soc_pkg::SEL_W-1:0]  o_slv_sel,
   output logic                        o_slv_we,
   output logic                        o_mem_stb,
   output logic                        o_timer_stb,
   output logic                        o_print_stb,
   output logic                        o_halt_stb,
   input  logic [soc_pkg::DATA_W-1:0] i_mem_rdt,
   input  logic                        i_mem_ack,
   input  logic [soc_pkg::DATA_W-1:0] i_timer_rdt,
   input  logic                        i_timer_ack,
   input  logic                        i_io_ack
);

   soc_pkg::arb_state_e state;
   soc_pkg::arb_state_e state_nxt;
   soc_pkg::region_e    region;

   logic                        ibus_req;
   logic                        dbus_req;
   logic                        gnt_ibus;
   logic                        gnt_dbus;
   logic                        req_act;
   logic                        none_ack;
   logic                        slv_ack;
   logic [soc_pkg::DATA_W-1:0] slv_rdt;

   assign ibus_req = i_ibus_cyc & i_ibus_stb;
   assign dbus_req = i_dbus_cyc & i_dbus_stb;

   // Idle grant is combinational with dbus first.
   assign gnt_dbus = (state == soc_pkg::ARB_DBUS) | ((state == soc_pkg::ARB_IDLE) & dbus_req);
   assign gnt_ibus = (state == soc_pkg::ARB_IBUS) |
                     ((state == soc_pkg::ARB_IDLE) & ~dbus_req & ibus_req);
   assign req_act  = (gnt_dbus & dbus_req) | (gnt_ibus & ibus_req);

   assign o_slv_adr = gnt_dbus ? i_dbus_adr : i_ibus_adr;
   assign o_slv_dat = i_dbus_dat;                   // ibus never writes.
   assign o_slv_sel = gnt_dbus ? i_dbus_sel : {soc_pkg::SEL_W{1'b1}};
   assign o_slv_we  = gnt_dbus & i_dbus_we;

   always_comb begin
      case (o_slv_adr[soc_pkg::ADDR_W-1 -: 4])
         soc_pkg::REGION_MEM:   region = soc_pkg::RGN_MEM;
         soc_pkg::REGION_PRINT: region = soc_pkg::RGN_PRINT;
         soc_pkg::REGION_TIMER: region = soc_pkg::RGN_TIMER;
         soc_pkg::REGION_HALT:  region = soc_pkg::RGN_HALT;
         default:               region = soc_pkg::RGN_NONE;
      endcase
   end

   assign o_mem_stb   = req_act & (region == soc_pkg::RGN_MEM);
   assign o_timer_stb = req_act & (region == soc_pkg::RGN_TIMER);
   assign o_print_stb = req_act & (region == soc_pkg::RGN_PRINT);
   assign o_halt_stb  = req_act & (region == soc_pkg::RGN_HALT);

   // Unmapped accesses still complete.
   always_ff @(posedge wb_clk) begin
      if (!i_rst_n)
         none_ack <= 1'b0;
      else
         none_ack <= req_act & (region == soc_pkg::RGN_NONE) & ~none_ack;
   end

   assign slv_ack = i_mem_ack | i_timer_ack | i_io_ack | none_ack;
   assign slv_rdt = i_mem_ack   ? i_mem_rdt   :
                    i_timer_ack ? i_timer_rdt : '0;

   always_comb begin
      state_nxt = state;
      case (state)
         soc_pkg::ARB_IDLE: begin
            if (dbus_req)
               state_nxt = soc_pkg::ARB_DBUS;
            else if (ibus_req)
               state_nxt = soc_pkg::ARB_IBUS;
         end
         soc_pkg::ARB_IBUS,
         soc_pkg::ARB_DBUS: begin
            if (slv_ack)
               state_nxt = soc_pkg::ARB_IDLE; // Grant ends with the ack.
         end
         default: state_nxt = soc_pkg::ARB_IDLE;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n)
         state <= soc_pkg::ARB_IDLE;
      else
         state <= state_nxt;
   end

   assign o_ibus_ack = slv_ack & (state == soc_pkg::ARB_IBUS);
   assign o_dbus_ack = slv_ack & (state == soc_pkg::ARB_DBUS);
   assign o_ibus_rdt = (state == soc_pkg::ARB_IBUS) ? slv_rdt : '0;
   assign o_dbus_rdt = (state == soc_pkg::ARB_DBUS) ? slv_rdt : '0;

   a_one_slave: assert property (@(posedge wb_clk) disable iff (!i_rst_n)
      $onehot0({o_mem_stb, o_timer_stb, o_print_stb, o_halt_stb}));

   a_ibus_ack_req: assert property (@(posedge wb_clk) disable iff (!i_rst_n)
      o_ibus_ack |-> ibus_req);

   a_dbus_ack_req: assert property (@(posedge wb_clk) disable iff (!i_rst_n)
      o_dbus_ack |-> dbus_req);

endmodule
`default_nettype wire

//--- wb_ram.sv
`timescale 1ns/1ps
`default_nettype none
module wb_ram (
   input  logic                                  wb_clk,
   input  logic                                  i_rst_n,
   input  logic [$clog2(soc_pkg::MEM_WORDS)-1:0] i_adr,
   input  logic [soc_pkg::DATA_W-1:0]           i_dat,
   input  logic [soc_pkg::SEL_W-1:0]            i_sel,
   input  logic                                  i_we,
   input  logic                                  i_stb,
   output logic [soc_pkg::DATA_W-1:0]           o_rdt,
   output logic                                  o_ack
);

   logic [soc_pkg::DATA_W-1:0] mem [soc_pkg::MEM_WORDS];

   logic access;

   // Second cycle of a held strobe is ignored.
   assign access = i_stb & ~o_ack;

   always_ff @(posedge wb_clk) begin
      if (access && i_we) begin
         for (int b = 0; b < soc_pkg::SEL_W; b++) begin
            if (i_sel[b])
               mem[i_adr][8*b +: 8] <= i_dat[8*b +: 8];
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (access)
         o_rdt <= mem[i_adr]; // Old word on a write.
   end

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n)
         o_ack <= 1'b0;
      else
         o_ack <= access;
   end

   a_ack_single: assert property (@(posedge wb_clk) disable iff (!i_rst_n)
      o_ack |=> !o_ack);

endmodule
`default_nettype wire

//--- riscv_timer.sv
`timescale 1ns/1ps
`default_nettype none
module riscv_timer (
   input  logic                        wb_clk,
   input  logic                        i_rst_n,
   input  logic [soc_pkg::DATA_W-1:0] i_dat,
   input  logic [soc_pkg::SEL_W-1:0]  i_sel,
   input  logic                        i_we,
   input  logic                        i_stb,
   output logic [soc_pkg::DATA_W-1:0] o_rdt,
   output logic                        o_ack,
   output logic                        o_irq
);

   logic [soc_pkg::DATA_W-1:0] mtime;
   logic [soc_pkg::DATA_W-1:0] mtimecmp;
   logic                        access;

   assign access = i_stb & ~o_ack;

   // Free-running counter without a prescaler.
   always_ff @(posedge wb_clk) begin
      if (!i_rst_n)
         mtime <= '0;
      else
         mtime <= mtime + 1'b1;
   end

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n) begin
         mtimecmp <= soc_pkg::TIMECMP_RESET;
      end else if (access && i_we) begin
         for (int b = 0; b < soc_pkg::SEL_W; b++) begin
            if (i_sel[b])
               mtimecmp[8*b +: 8] <= i_dat[8*b +: 8];
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (access)
         o_rdt <= mtime; // Reads always see mtime.
   end

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n)
         o_ack <= 1'b0;
      else
         o_ack <= access;
   end

   // Level that stays up until mtimecmp moves past mtime.
   assign o_irq = (mtime >= mtimecmp);

endmodule
`default_nettype wire

//--- sim_io.sv
`timescale 1ns/1ps
`default_nettype none
module sim_io (
   input  logic                        wb_clk,
   input  logic                        i_rst_n,
   input  logic [soc_pkg::DATA_W-1:0] i_dat,
   input  logic [soc_pkg::SEL_W-1:0]  i_sel,
   input  logic                        i_we,
   input  logic                        i_print_stb,
   input  logic                        i_halt_stb,
   output logic                        o_ack,
   output logic [7:0]                  o_print_char,
   output logic                        o_print_valid,
   output logic                        o_halt
);

   logic print_wr;
   logic halt_wr;

   assign print_wr = i_print_stb & i_we & i_sel[0] & ~o_ack;
   assign halt_wr  = i_halt_stb & i_we & ~o_ack;

   always_ff @(posedge wb_clk) begin
      if (print_wr)
         o_print_char <= i_dat[7:0]; // Lane 0 only.
   end

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n) begin
         o_ack         <= 1'b0;
         o_print_valid <= 1'b0;
         o_halt        <= 1'b0;
      end else begin
         o_ack         <= (i_print_stb | i_halt_stb) & ~o_ack;
         o_print_valid <= print_wr;
         o_halt        <= o_halt | halt_wr; // Sticky until reset.
      end
   end

   a_print_pulse: assert property (@(posedge wb_clk) disable iff (!i_rst_n)
      o_print_valid |=> !o_print_valid);

endmodule
`default_nettype wire

//--- serv_wrapper.sv
`timescale 1ns/1ps
`default_nettype none
module serv_wrapper (
   input  logic                        wb_clk,
   input  logic                        i_rst_n,
   input  logic [soc_pkg::ADDR_W-1:0] i_ibus_adr,
   input  logic                        i_ibus_cyc,
   input  logic                        i_ibus_stb,
   output logic [soc_pkg::DATA_W-1:0] o_ibus_rdt,
   output logic                        o_ibus_ack,
   input  logic [soc_pkg::ADDR_W-1:0] i_dbus_adr,
   input  logic [soc_pkg::DATA_W-1:0] i_dbus_dat,
   input  logic [soc_pkg::SEL_W-1:0]  i_dbus_sel,
   input  logic                        i_dbus_we,
   input  logic                        i_dbus_cyc,
   input  logic                        i_dbus_stb,
   output logic [soc_pkg::DATA_W-1:0] o_dbus_rdt,
   output logic                        o_dbus_ack,
   output logic                        o_timer_irq,
   output logic [7:0]                  o_print_char,
   output logic                        o_print_valid,
   output logic                        o_halt
);

   logic [soc_pkg::RST_STRETCH-1:0] rst_sr;
   logic                             rst_n_int;

   logic [soc_pkg::ADDR_W-1:0] slv_adr;
   logic [soc_pkg::DATA_W-1:0] slv_dat;
   logic [soc_pkg::SEL_W-1:0]  slv_sel;
   logic                        slv_we;
   logic                        mem_stb;
   logic                        timer_stb;
   logic                        print_stb;
   logic                        halt_stb;
   logic [soc_pkg::DATA_W-1:0] mem_rdt;
   logic                        mem_ack;
   logic [soc_pkg::DATA_W-1:0] timer_rdt;
   logic                        timer_ack;
   logic                        io_ack;

   // Ones shift out after the external reset goes away.
   always_ff @(posedge wb_clk) begin
      if (!i_rst_n)
         rst_sr <= '1;
      else
         rst_sr <= {1'b0, rst_sr[soc_pkg::RST_STRETCH-1:1]};
   end

   assign rst_n_int = ~rst_sr[0];

   wb_intercon intercon (
      .wb_clk      (wb_clk),
      .i_rst_n     (rst_n_int),
      .i_ibus_adr  (i_ibus_adr),
      .i_ibus_cyc  (i_ibus_cyc),
      .i_ibus_stb  (i_ibus_stb),
      .o_ibus_rdt  (o_ibus_rdt),
      .o_ibus_ack  (o_ibus_ack),
      .i_dbus_adr  (i_dbus_adr),
      .i_dbus_dat  (i_dbus_dat),
      .i_dbus_sel  (i_dbus_sel),
      .i_dbus_we   (i_dbus_we),
      .i_dbus_cyc  (i_dbus_cyc),
      .i_dbus_stb  (i_dbus_stb),
      .o_dbus_rdt  (o_dbus_rdt),
      .o_dbus_ack  (o_dbus_ack),
      .o_slv_adr   (slv_adr),
      .o_slv_dat   (slv_dat),
      .o_slv_sel   (slv_sel),
      .o_slv_we    (slv_we),
      .o_mem_stb   (mem_stb),
      .o_timer_stb (timer_stb),
      .o_print_stb (print_stb),
      .o_halt_stb  (halt_stb),
      .i_mem_rdt   (mem_rdt),
      .i_mem_ack   (mem_ack),
      .i_timer_rdt (timer_rdt),
      .i_timer_ack (timer_ack),
      .i_io_ack    (io_ack)
   );

   wb_ram ram (
      .wb_clk  (wb_clk),
      .i_rst_n (rst_n_int),
      .i_adr   (slv_adr[$clog2(soc_pkg::MEM_WORDS)+1:2]), // Byte to word address.
      .i_dat   (slv_dat),
      .i_sel   (slv_sel),
      .i_we    (slv_we),
      .i_stb   (mem_stb),
      .o_rdt   (mem_rdt),
      .o_ack   (mem_ack)
   );

   riscv_timer timer (
      .wb_clk  (wb_clk),
      .i_rst_n (rst_n_int),
      .i_dat   (slv_dat),
      .i_sel   (slv_sel),
      .i_we    (slv_we),
      .i_stb   (timer_stb),
      .o_rdt   (timer_rdt),
      .o_ack   (timer_ack),
      .o_irq   (o_timer_irq)
   );

   sim_io sim_io (
      .wb_clk        (wb_clk),
      .i_rst_n       (rst_n_int),
      .i_dat         (slv_dat),
      .i_sel         (slv_sel),
      .i_we          (slv_we),
      .i_print_stb   (print_stb),
      .i_halt_stb    (halt_stb),
      .o_ack         (io_ack),
      .o_print_char  (o_print_char),
      .o_print_valid (o_print_valid),
      .o_halt        (o_halt)
   );

   a_rst_stretch: assert property (@(posedge wb_clk)
      $rose(i_rst_n) |-> (!rst_n_int) [*soc_pkg::RST_STRETCH]);

endmodule
`default_nettype wire

//--- wb_checker.sv
`timescale 1ns/1ps
module wb_checker (
   input  logic        wb_clk,
   input  logic        i_rst_n,
   input  logic [31:0] i_ibus_adr,
   input  logic        i_ibus_cyc,
   input  logic        i_ibus_stb,
   input  logic [31:0] i_ibus_rdt,
   input  logic        i_ibus_ack,
   input  logic [31:0] i_dbus_adr,
   input  logic [31:0] i_dbus_dat,
   input  logic [3:0]  i_dbus_sel,
   input  logic        i_dbus_we,
   input  logic        i_dbus_cyc,
   input  logic        i_dbus_stb,
   input  logic [31:0] i_dbus_rdt,
   input  logic        i_dbus_ack,
   input  logic        i_timer_irq,
   input  logic [7:0]  i_print_char,
   input  logic        i_print_valid,
   input  logic        i_halt,
   output int          o_errors,
   output int          o_checks
);

   logic [31:0] shadow [soc_pkg::MEM_WORDS];
   logic [31:0] cmp_model;
   logic [31:0] mtime_model;
   logic [31:0] last_mtime;
   logic        mtime_known;
   logic        halt_model;
   logic        pv_exp;
   logic        irq_exp;
   logic [3:0]  rgn;
   int          rst_cycles;

   // Expected read word by region.
   function automatic logic [31:0] expected_rdt(input logic [31:0] adr);
      if (adr[31:28] == soc_pkg::REGION_MEM)
         return shadow[adr[$clog2(soc_pkg::MEM_WORDS)+1:2]];
      return 32'd0;
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      o_checks++;
      if (got !== exp) begin
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
         o_errors++;
      end
   endtask

   task automatic report(input string what);
      $display("Check failed: %s at %0t", what, $time);
      o_errors++;
   endtask

   initial begin
      o_errors   = 0;
      o_checks   = 0;
      rst_cycles = 0;
   end

   always @(posedge wb_clk) begin
      if (!i_rst_n) begin
         rst_cycles  = 0;
         cmp_model   = '1;
         mtime_known = 1'b0;
         halt_model  = 1'b0;
      end else begin
         rgn = i_dbus_adr[31:28];
         if (rst_cycles <= soc_pkg::RST_STRETCH) begin
            compare("o_ibus_ack", {31'd0, i_ibus_ack}, 32'd0); // Still in stretched reset.
            compare("o_dbus_ack", {31'd0, i_dbus_ack}, 32'd0);
            rst_cycles++;
         end
         if (i_ibus_ack && !(i_ibus_cyc && i_ibus_stb))
            report("ibus ack without a request");
         if (i_dbus_ack && !(i_dbus_cyc && i_dbus_stb))
            report("dbus ack without a request");
         if (i_ibus_ack)
            compare("o_ibus_rdt", i_ibus_rdt, expected_rdt(i_ibus_adr));
         pv_exp = 1'b0;
         if (i_dbus_ack && i_dbus_we) begin
            for (int b = 0; b < 4; b++) begin
               if (i_dbus_sel[b] && rgn == soc_pkg::REGION_MEM)
                  shadow[i_dbus_adr[$clog2(soc_pkg::MEM_WORDS)+1:2]][8*b +: 8] =
                     i_dbus_dat[8*b +: 8];
               if (i_dbus_sel[b] && rgn == soc_pkg::REGION_TIMER)
                  cmp_model[8*b +: 8] = i_dbus_dat[8*b +: 8];
            end
            pv_exp = (rgn == soc_pkg::REGION_PRINT) && i_dbus_sel[0];
            if (rgn == soc_pkg::REGION_HALT)
               halt_model = 1'b1;
         end else if (i_dbus_ack && rgn == soc_pkg::REGION_TIMER) begin
            if (mtime_known && i_dbus_rdt <= last_mtime)
               report("timer read did not increase");
            last_mtime  = i_dbus_rdt;
            mtime_model = i_dbus_rdt + 32'd1; // Ack cycle is one past the access.
            mtime_known = 1'b1;
         end else if (i_dbus_ack) begin
            compare("o_dbus_rdt", i_dbus_rdt, expected_rdt(i_dbus_adr));
         end
         compare("o_print_valid", {31'd0, i_print_valid}, {31'd0, pv_exp});
         if (pv_exp)
            compare("o_print_char", {24'd0, i_print_char}, {24'd0, i_dbus_dat[7:0]});
         compare("o_halt", {31'd0, i_halt}, {31'd0, halt_model});
         if (mtime_known || cmp_model == '1) begin
            irq_exp = mtime_known && (mtime_model >= cmp_model);
            compare("o_timer_irq", {31'd0, i_timer_irq}, {31'd0, irq_exp});
         end
         mtime_model = mtime_model + 32'd1;
      end
   end

endmodule

//--- tb_serv_wrapper.sv
`timescale 1ns/1ps
module tb_serv_wrapper;

   localparam int N_FILL      = 64;  // RAM words written before the random phase.
   localparam int N_RAND      = 100;
   localparam int IRQ_WAIT    = 100;
   localparam int CYC_PER_ACC = 5;
   // About three times the expected run length.
   localparam int MAX_CYCLES  =
      3 * ((N_FILL + 2 * N_RAND + 20) * CYC_PER_ACC + 2 * IRQ_WAIT + 30);

   logic        wb_clk;
   logic        i_rst_n;
   logic [31:0] i_ibus_adr;
   logic        i_ibus_cyc;
   logic        i_ibus_stb;
   logic [31:0] o_ibus_rdt;
   logic        o_ibus_ack;
   logic [31:0] i_dbus_adr;
   logic [31:0] i_dbus_dat;
   logic [3:0]  i_dbus_sel;
   logic        i_dbus_we;
   logic        i_dbus_cyc;
   logic        i_dbus_stb;
   logic [31:0] o_dbus_rdt;
   logic        o_dbus_ack;
   logic        o_timer_irq;
   logic [7:0]  o_print_char;
   logic        o_print_valid;
   logic        o_halt;

   logic [31:0] seed;
   logic [31:0] adr;
   logic [31:0] rdata;
   logic [31:0] rdata2;
   int          cycles = 0;
   int          misc_errors;
   int          errs_before;
   int          chk_errors;
   int          chk_checks;
   int          dbus_ack_cyc;
   int          ibus_ack_cyc;
   int          irq_wait;

   serv_wrapper dut0 (.*);

   wb_checker checker0 (
      .wb_clk        (wb_clk),
      .i_rst_n       (i_rst_n),
      .i_ibus_adr    (i_ibus_adr),
      .i_ibus_cyc    (i_ibus_cyc),
      .i_ibus_stb    (i_ibus_stb),
      .i_ibus_rdt    (o_ibus_rdt),
      .i_ibus_ack    (o_ibus_ack),
      .i_dbus_adr    (i_dbus_adr),
      .i_dbus_dat    (i_dbus_dat),
      .i_dbus_sel    (i_dbus_sel),
      .i_dbus_we     (i_dbus_we),
      .i_dbus_cyc    (i_dbus_cyc),
      .i_dbus_stb    (i_dbus_stb),
      .i_dbus_rdt    (o_dbus_rdt),
      .i_dbus_ack    (o_dbus_ack),
      .i_timer_irq   (o_timer_irq),
      .i_print_char  (o_print_char),
      .i_print_valid (o_print_valid),
      .i_halt        (o_halt),
      .o_errors      (chk_errors),
      .o_checks      (chk_checks)
   );

   always #2 wb_clk = ~wb_clk;

   always @(posedge wb_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
         $display("Something failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Held until acked, released after the acking edge.
   task automatic dbus_access(input logic [31:0] a, input logic we, input logic [31:0] dat,
                              input logic [3:0] sel, output logic [31:0] rdt);
      i_dbus_adr = a;
      i_dbus_dat = dat;
      i_dbus_sel = sel;
      i_dbus_we  = we;
      i_dbus_cyc = 1'b1;
      i_dbus_stb = 1'b1;
      @(negedge wb_clk);
      while (o_dbus_ack !== 1'b1)
         @(negedge wb_clk);
      rdt          = o_dbus_rdt;
      dbus_ack_cyc = cycles;
      @(negedge wb_clk);
      i_dbus_cyc = 1'b0;
      i_dbus_stb = 1'b0;
      i_dbus_we  = 1'b0;
   endtask

   task automatic ibus_read(input logic [31:0] a, output logic [31:0] rdt);
      i_ibus_adr = a;
      i_ibus_cyc = 1'b1;
      i_ibus_stb = 1'b1;
      @(negedge wb_clk);
      while (o_ibus_ack !== 1'b1)
         @(negedge wb_clk);
      rdt          = o_ibus_rdt;
      ibus_ack_cyc = cycles;
      @(negedge wb_clk);
      i_ibus_cyc = 1'b0;
      i_ibus_stb = 1'b0;
   endtask

   task automatic end_test(input string name);
      $display("test %-8s done, %0d errors", name, chk_errors + misc_errors - errs_before);
      errs_before = chk_errors + misc_errors;
   endtask

   initial begin
      seed        = 32'h04c8d766;
      misc_errors = 0;
      errs_before = 0;
      wb_clk      = 1'b0;
      i_rst_n     = 1'b0;
      i_ibus_adr  = '0;
      i_ibus_cyc  = 1'b0;
      i_ibus_stb  = 1'b0;
      i_dbus_adr  = '0;
      i_dbus_dat  = '0;
      i_dbus_sel  = '0;
      i_dbus_we   = 1'b0;
      i_dbus_cyc  = 1'b0;
      i_dbus_stb  = 1'b0;
      repeat (2) @(negedge wb_clk);
      i_rst_n = 1'b1;
      repeat (8) @(negedge wb_clk); // Covers the stretched reset.
      end_test("reset");

      for (int i = 0; i < N_FILL; i++) begin
         seed = xorshift(seed);
         dbus_access(32'(4 * i), 1'b1, seed, 4'hf, rdata);
      end
      for (int i = 0; i < N_RAND; i++) begin
         seed = xorshift(seed);
         adr  = {24'h0, seed[7:2], 2'b00};
         seed = xorshift(seed);
         dbus_access(adr, 1'b1, seed, seed[31:28], rdata);
         seed = xorshift(seed);
         dbus_access({24'h0, seed[7:2], 2'b00}, 1'b0, '0, 4'hf, rdata);
      end
      end_test("ram");

      for (int i = 0; i < 8; i++)
         ibus_read(32'(4 * i), rdata);
      fork
         dbus_access(32'h0000_0010, 1'b0, '0, 4'hf, rdata);
         ibus_read(32'h0000_0020, rdata2);
      join
      if (dbus_ack_cyc >= ibus_ack_cyc) begin
         $display("Under contention the dbus ack did not come before the ibus ack.");
         misc_errors++;
      end
      end_test("ibus");

      dbus_access(32'h8000_0000, 1'b0, '0, 4'hf, rdata);
      dbus_access(32'h8000_0000, 1'b0, '0, 4'hf, rdata);
      dbus_access(32'h8000_0000, 1'b1, rdata + 32'd60, 4'hf, rdata2);
      irq_wait = 0;
      while (o_timer_irq !== 1'b1 && irq_wait < IRQ_WAIT) begin
         @(negedge wb_clk);
         irq_wait++;
      end
      if (o_timer_irq !== 1'b1) begin
         $display("Timer interrupt still low %0d cycles after the compare write.", IRQ_WAIT);
         misc_errors++;
      end
      end_test("timer");

      dbus_access(32'h1000_0000, 1'b1, 32'h0000_0041, 4'h1, rdata);
      dbus_access(32'h9000_0000, 1'b1, 32'h0000_0001, 4'hf, rdata);
      dbus_access(32'h0000_0004, 1'b0, '0, 4'hf, rdata);
      ibus_read(32'h0000_0008, rdata);
      end_test("io");

      dbus_access(32'h4000_0000, 1'b0, '0, 4'hf, rdata);
      ibus_read(32'hc000_0100, rdata);
      end_test("unmapped");

      repeat (2) @(negedge wb_clk);
      $display("checks %0d, errors %0d", chk_checks, chk_errors + misc_errors);
      if (chk_errors + misc_errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

//--- serv_wrapper.f
soc_pkg.sv
wb_intercon.sv
wb_ram.sv
riscv_timer.sv
sim_io.sv
serv_wrapper.sv
wb_checker.sv
tb_serv_wrapper.sv

//--- Bender.yml
package:
  name: serv_wrapper

sources:
  - soc_pkg.sv
  - wb_intercon.sv
  - wb_ram.sv
  - riscv_timer.sv
  - sim_io.sv
  - serv_wrapper.sv
  - target: simulation
    files:
      - wb_checker.sv
      - tb_serv_wrapper.sv
